// ==== hdl/boot_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_loader import cpc_pkg::*; (
    input  logic                 clk_48,
    input  logic                 reset,
    input  logic                 ioctl_download,
    input  logic                 ioctl_wr,
    input  logic [IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic [7:0]           ioctl_index,
    output logic                 core_reset,
    output logic                 rom_loaded,
    output logic                 boot_wr,
    output logic [BOOT_AW-1:0]   boot_a,
    output logic [7:0]           boot_dout,
    output logic [ROM_MAP_W-1:0] rom_map
);

    localparam int SLOT_LIMIT = 16; // 16 KB slots accepted from a ROM image

    logic [IOCTL_AW-15:0] slot;        // Download address in 16 KB units
    logic                 byte_acc;    // Byte transferred this clock
    logic                 rom_dl;
    logic [8:0]           slot_bank;
    logic                 slot_mapped;
    logic                 download_d;  // Previous ioctl_download

    assign slot     = ioctl_addr[IOCTL_AW-1:14];
    assign byte_acc = ioctl_download & ioctl_wr;
    assign rom_dl   = (ioctl_index < IDX_ROM_LIMIT) && (slot < SLOT_LIMIT);

    // Slot remapping --------------------
    always_comb begin
        slot_bank   = BANK_OS;
        slot_mapped = 1'b1;
        case (slot)
            0:       slot_bank = BANK_OS;
            1:       slot_bank = BANK_BASIC;
            2:       slot_bank = BANK_AMSDOS;
            3:       slot_bank = BANK_MF2;
            default: slot_mapped = 1'b0; // Slots 4..15 are dropped
        endcase
    end

    // Write strobe, one clock after the accepted byte
    always_ff @(posedge clk_48) begin
        if (reset) begin
            boot_wr <= 1'b0;
        end else begin
            boot_wr <= byte_acc & rom_dl & slot_mapped;
        end
    end

    // Address and data follow every accepted byte
    always_ff @(posedge clk_48) begin
        if (byte_acc) begin
            boot_a    <= {slot_bank, ioctl_addr[13:0]};
            boot_dout <= ioctl_dout;
        end
    end

    // ROM map --------------------
    // Upper ROMs live in banks with bit 22 set, index in bits 21:14
    always_ff @(posedge clk_48) begin
        if (reset) begin
            rom_map <= '0;
        end else if (boot_wr) begin
            if (boot_a[22]) begin
                rom_map[boot_a[21:14]] <= 1'b1;
            end
            if (boot_a[22:14] == 9'h000) begin
                rom_map[boot_a[17:14]] <= 1'b1; // Lower ROM bank
            end
        end
    end

    // Core reset sequencing --------------------
    always_ff @(posedge clk_48) begin
        if (reset) begin
            download_d <= 1'b0;
            core_reset <= 1'b1; // Core held until firmware is in
            rom_loaded <= 1'b0;
        end else begin
            download_d <= ioctl_download;
            if (download_d && !ioctl_download) begin
                rom_loaded <= 1'b1; // End of transfer
                core_reset <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpc_pkg.sv ====
`default_nettype none

package cpc_pkg;

    // Bus widths --------------------
    localparam int IOCTL_AW  = 25;  // Download address
    localparam int BOOT_AW   = 23;  // Memory address, 9 bank bits over 14 offset bits
    localparam int CPU_AW    = 16;  // Z80 address
    localparam int MF2_AW    = 13;  // 8 KB MF2 RAM
    localparam int ROM_MAP_W = 256; // One bit per upper ROM

    // Firmware slot banks --------------------
    localparam logic [8:0] BANK_OS     = 9'h000; // OS6128
    localparam logic [8:0] BANK_BASIC  = 9'h100; // BASIC 1.1
    localparam logic [8:0] BANK_AMSDOS = 9'h107; // AMSDOS in upper ROM 7
    localparam logic [8:0] BANK_MF2    = 9'h0FF; // Multiface ROM

    localparam logic [7:0] IDX_ROM_LIMIT = 8'd4; // Indexes 0..3 are ROM images

    // MF2 fetch vectors and enable ports --------------------
    localparam logic [CPU_AW-1:0] NMI_VECTOR  = 16'h0066;
    localparam logic [CPU_AW-1:0] HIDE_VECTOR = 16'h0065;
    localparam logic [13:0]       MF2_PORT_BASE = 14'h3FBA; // FEE8 and FEEA

    // Shadowed I/O port codes, address bits 15:8
    localparam logic [7:0] PORT_GA        = 8'h7F; // Gate array
    localparam logic [7:0] PORT_CRTC_SEL  = 8'hBC;
    localparam logic [7:0] PORT_CRTC_DATA = 8'hBD;
    localparam logic [7:0] PORT_PPI       = 8'hF7; // 8255 control
    localparam logic [7:0] PORT_UPPER_ROM = 8'hDF;

    // Shadow locations in MF2 RAM --------------------
    localparam logic [MF2_AW-1:0] SH_PEN_INDEX  = 13'h1FCF;
    localparam logic [MF2_AW-1:0] SH_BORDER     = 13'h1FDF;
    localparam logic [MF2_AW-1:0] SH_PEN_BASE   = 13'h1F90; // Plus pen 0..15
    localparam logic [MF2_AW-1:0] SH_MODE       = 13'h1FEF;
    localparam logic [MF2_AW-1:0] SH_BANKING    = 13'h1FFF;
    localparam logic [MF2_AW-1:0] SH_CRTC_SEL   = 13'h1CFF;
    localparam logic [MF2_AW-1:0] SH_CRTC_BASE  = 13'h1DB0; // Plus register number
    localparam logic [MF2_AW-1:0] SH_PPI        = 13'h17FF;
    localparam logic [MF2_AW-1:0] SH_UPPER_ROM  = 13'h1AAC;

endpackage

`default_nettype wire

// ==== hdl/cpc_sim_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpc_sim_top import cpc_pkg::*; (
    input  logic                 clk_48,
    input  logic                 reset,
    // Download port
    input  logic                 ioctl_download,
    input  logic                 ioctl_wr,
    input  logic [IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic [7:0]           ioctl_index,
    // CPU bus
    input  logic [CPU_AW-1:0]    cpu_addr,
    input  logic [7:0]           cpu_dout,
    input  logic                 m1,
    input  logic                 iorq,
    input  logic                 wr,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 key_nmi,
    output logic                 core_reset,
    output logic                 rom_loaded,
    output logic                 boot_wr,
    output logic [BOOT_AW-1:0]   boot_a,
    output logic [7:0]           boot_dout,
    output logic [ROM_MAP_W-1:0] rom_map,
    output logic                 mf2_en,
    output logic                 mf2_rom_en,
    output logic [7:0]           mf2_dout
);

    logic              mf2_ram_en;
    logic              store_hit, store_req, user_wr;
    logic [MF2_AW-1:0] ram_a;
    logic [7:0]        ram_din, ram_dout;
    logic              ram_we;

    // Open bus reads as FF, ANDed with the main memory data upstream
    assign mf2_dout = (mf2_ram_en & mem_rd) ? ram_dout : 8'hFF;

    // --------------------
    boot_loader boot_loader_i (
        .clk_48, .reset, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
        .ioctl_index, .core_reset, .rom_loaded, .boot_wr, .boot_a, .boot_dout, .rom_map
    );

    mf2_control mf2_control_i (
        .clk_48, .core_reset, .cpu_addr, .m1, .iorq, .wr, .mem_wr, .key_nmi,
        .store_hit, .mf2_en, .mf2_rom_en, .mf2_ram_en, .store_req, .user_wr
    );

    mf2_shadow mf2_shadow_i (
        .clk_48, .cpu_addr, .cpu_dout, .store_req, .user_wr,
        .store_hit, .ram_a, .ram_din, .ram_we
    );

    mf2_ram mf2_ram_i (
        .clk_48, .ram_a, .ram_din, .ram_we, .ram_dout
    );

endmodule

`default_nettype wire

// ==== hdl/mf2_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mf2_control import cpc_pkg::*; (
    input  logic              clk_48,
    input  logic              core_reset,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic              m1,
    input  logic              iorq,
    input  logic              wr,
    input  logic              mem_wr,
    input  logic              key_nmi,
    input  logic              store_hit,
    output logic              mf2_en,
    output logic              mf2_rom_en,
    output logic              mf2_ram_en,
    output logic              store_req,
    output logic              user_wr
);

    logic io_wr;
    logic key_nmi_d, m1_d, io_wr_d; // Edge history
    logic nmi_rise, m1_rise, io_wr_rise;
    logic nmi_pend;   // Key pressed and waiting for the 0x66 fetch
    logic hidden;     // Set by the 0x65 fetch
    logic mem_wr_done; // One user write per memory cycle

    assign io_wr      = iorq & wr;
    assign nmi_rise   = key_nmi & ~key_nmi_d;
    assign m1_rise    = m1 & ~m1_d;
    assign io_wr_rise = io_wr & ~io_wr_d;

    // ROM at 0000..1FFF and RAM at 2000..3FFF
    assign mf2_rom_en = mf2_en & (cpu_addr[15:13] == 3'b000);
    assign mf2_ram_en = mf2_en & (cpu_addr[15:13] == 3'b001);

    always_ff @(posedge clk_48) begin
        key_nmi_d <= key_nmi;
        m1_d      <= m1;
        io_wr_d   <= io_wr;
    end

    // Enable state and RAM commands --------------------
    always_ff @(posedge clk_48) begin
        if (core_reset) begin
            mf2_en      <= 1'b0;
            hidden      <= 1'b0;
            nmi_pend    <= 1'b0;
            store_req   <= 1'b0;
            user_wr     <= 1'b0;
            mem_wr_done <= 1'b0;
        end else begin
            store_req <= 1'b0;
            user_wr   <= 1'b0;
            if (nmi_rise && !mf2_en) nmi_pend <= 1'b1; // Arm
            if (nmi_pend && m1_rise && cpu_addr == NMI_VECTOR) begin
                mf2_en   <= 1'b1;
                hidden   <= 1'b0;
                nmi_pend <= 1'b0;
            end
            if (mf2_en && m1_rise && cpu_addr == HIDE_VECTOR) hidden <= 1'b1;

            if (!mem_wr) mem_wr_done <= 1'b0;

            if (io_wr_rise && cpu_addr[15:2] == MF2_PORT_BASE) begin
                mf2_en <= ~cpu_addr[1] & ~hidden; // FEE8 turns on and FEEA off
            end else if (io_wr_rise && store_hit) begin
                store_req <= 1'b1;
            end else if (mem_wr && mf2_ram_en && !mem_wr_done) begin
                user_wr     <= 1'b1;
                mem_wr_done <= 1'b1;
            end
        end
    end

    // A Z80 never mixes an I/O write and a memory write in one cycle
    a_bus_excl: assert property (@(posedge clk_48) !(io_wr && mem_wr))
        else $error("I/O write and memory write in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/mf2_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mf2_ram import cpc_pkg::*; (
    input  logic              clk_48,
    input  logic [MF2_AW-1:0] ram_a,
    input  logic [7:0]        ram_din,
    input  logic              ram_we,
    output logic [7:0]        ram_dout
);

    logic [7:0] mem [0:(1 << MF2_AW) - 1]; // 8192 bytes

    // Single port, write-first
    always_ff @(posedge clk_48) begin
        if (ram_we) begin
            mem[ram_a] <= ram_din;
            ram_dout   <= ram_din; // Written byte shows on the output
        end else begin
            ram_dout   <= mem[ram_a];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mf2_shadow.sv ====
`timescale 1ns/1ps
`default_nettype none

module mf2_shadow import cpc_pkg::*; (
    input  logic              clk_48,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [7:0]        cpu_dout,
    input  logic              store_req,
    input  logic              user_wr,
    output logic              store_hit,
    output logic [MF2_AW-1:0] ram_a,
    output logic [7:0]        ram_din,
    output logic              ram_we
);

    logic [7:0]        port;
    logic [MF2_AW-1:0] store_addr;
    logic [4:0]        pen_index;  // Last gate array pen select
    logic [3:0]        crtc_reg;   // Last CRTC register select

    assign port = cpu_addr[15:8];

    // Port decode --------------------
    always_comb begin
        case (port)
            PORT_GA: begin
                case (cpu_dout[7:6]) // Gate array function
                    2'b00:   store_addr = SH_PEN_INDEX;
                    2'b01:   store_addr = pen_index[4] ? SH_BORDER
                                        : SH_PEN_BASE + {9'd0, pen_index[3:0]};
                    2'b10:   store_addr = SH_MODE;
                    default: store_addr = SH_BANKING;
                endcase
            end
            PORT_CRTC_SEL:  store_addr = SH_CRTC_SEL;
            PORT_CRTC_DATA: store_addr = SH_CRTC_BASE + {9'd0, crtc_reg};
            PORT_PPI:       store_addr = SH_PPI;
            PORT_UPPER_ROM: store_addr = SH_UPPER_ROM;
            default:        store_addr = '0; // Not shadowed
        endcase
    end

    assign store_hit = |store_addr;

    // Registered RAM port --------------------
    always_ff @(posedge clk_48) begin
        if (store_req) begin
            if (port == PORT_GA && cpu_dout[7:6] == 2'b00) pen_index <= cpu_dout[4:0];
            if (port == PORT_CRTC_SEL) crtc_reg <= cpu_dout[3:0];
            ram_a   <= store_addr;
            ram_din <= cpu_dout;
            ram_we  <= 1'b1;
        end else if (user_wr) begin
            ram_a   <= cpu_addr[MF2_AW-1:0]; // CPU write in the RAM window
            ram_din <= cpu_dout;
            ram_we  <= 1'b1;
        end else begin
            ram_a   <= cpu_addr[MF2_AW-1:0]; // Read follows the bus
            ram_we  <= 1'b0;
        end
    end

    // Commands from the controller are single pulses
    a_we_pulse: assert property (@(posedge clk_48) ram_we |=> !ram_we)
        else $error("ram_we held longer than one clock");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_top &&
./obj_dir/tb_top | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpc_pkg::*; ();

    localparam int DL_BYTES    = 8;    // Bytes per firmware slot
    localparam int N_IO        = 300;  // Random shadowed port writes
    localparam int N_MEM       = 100;  // Random RAM window writes
    localparam int TEST_CYCLES = 16 + 7 * DL_BYTES + 10 + 3 * (N_IO + 3) + 4 * N_MEM
                               + (N_IO + N_MEM + 3) + 40;
    localparam int TIMEOUT     = 2 * TEST_CYCLES;

    // Codes of the observed DUT outputs
    localparam int SIG_BOOT_WR = 0, SIG_BOOT_A = 1, SIG_BOOT_DOUT = 2, SIG_ROM_MAP = 3;
    localparam int SIG_ROM_LOADED = 4, SIG_CORE_RESET = 5, SIG_MF2_EN = 6;
    localparam int SIG_MF2_ROM_EN = 7, SIG_MF2_DOUT = 8;

    logic                 clk_48;
    logic                 reset;
    logic                 ioctl_download;
    logic                 ioctl_wr;
    logic [IOCTL_AW-1:0]  ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic [7:0]           ioctl_index;
    logic [CPU_AW-1:0]    cpu_addr;
    logic [7:0]           cpu_dout;
    logic                 m1;
    logic                 iorq;
    logic                 wr;
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 key_nmi;
    logic                 core_reset;
    logic                 rom_loaded;
    logic                 boot_wr;
    logic [BOOT_AW-1:0]   boot_a;
    logic [7:0]           boot_dout;
    logic [ROM_MAP_W-1:0] rom_map;
    logic                 mf2_en;
    logic                 mf2_rom_en;
    logic [7:0]           mf2_dout;

    int           cyc = 0;        // Rising edges seen
    int           n_chk = 0;
    int           n_err = 0;
    int           chk_base = 0;   // Counts at the start of the current test
    int           err_base = 0;
    int           due_q[$];       // Pending checks, in due order
    int           code_q[$];
    logic [255:0] exp_q[$];
    logic [255:0] got;
    logic [15:0]  lfsr = 16'd62631;
    logic [4:0]   tb_pen = '0;    // Reference pen and CRTC select latches
    logic [3:0]   tb_crtc = '0;
    logic [7:0]   ref_mem [0:8191];
    logic [12:0]  written_q[$];   // RAM addresses to read back
    logic [255:0] exp_map = '0;

    cpc_sim_top cpc_sim_top_i (.*);

    initial begin
        clk_48 = 1'b0;
        forever #50 clk_48 = ~clk_48; // 100 ns period
    end

    // Reference model --------------------
    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Bit 9 set when the byte is written
    function automatic logic [9:0] boot_bank(input int slot, input logic [7:0] idx);
        if (idx >= 8'd4) return 10'h000; // Not a ROM image
        case (slot)
            0:       return {1'b1, 9'h000};
            1:       return {1'b1, 9'h100};
            2:       return {1'b1, 9'h107};
            3:       return {1'b1, 9'h0FF};
            default: return 10'h000;
        endcase
    endfunction

    function automatic int rom_map_bit(input logic [8:0] bank);
        if (bank[8]) return int'(bank[7:0]); // Upper ROM number
        if (bank == 9'h000) return 0;
        return -1;
    endfunction

    function automatic logic [12:0] shadow_addr(input logic [7:0] port, input logic [7:0] data,
                                                input logic [4:0] pen, input logic [3:0] crtc);
        case (port)
            8'h7F: begin
                case (data[7:6])
                    2'b00:   return 13'h1FCF;
                    2'b01:   return pen[4] ? 13'h1FDF : 13'h1F90 + 13'(pen[3:0]);
                    2'b10:   return 13'h1FEF;
                    default: return 13'h1FFF;
                endcase
            end
            8'hBC:   return 13'h1CFF;
            8'hBD:   return 13'h1DB0 + 13'(crtc);
            8'hF7:   return 13'h17FF;
            8'hDF:   return 13'h1AAC;
            default: return 13'h0000;
        endcase
    endfunction

    // Compare --------------------
    function automatic logic [255:0] probe(input int code);
        case (code)
            SIG_BOOT_WR:    return 256'(boot_wr);
            SIG_BOOT_A:     return 256'(boot_a);
            SIG_BOOT_DOUT:  return 256'(boot_dout);
            SIG_ROM_MAP:    return rom_map;
            SIG_ROM_LOADED: return 256'(rom_loaded);
            SIG_CORE_RESET: return 256'(core_reset);
            SIG_MF2_EN:     return 256'(mf2_en);
            SIG_MF2_ROM_EN: return 256'(mf2_rom_en);
            default:        return 256'(mf2_dout);
        endcase
    endfunction

    function automatic string sig_name(input int code);
        string names [9] = '{"boot_wr", "boot_a", "boot_dout", "rom_map", "rom_loaded",
                             "core_reset", "mf2_en", "mf2_rom_en", "mf2_dout"};
        return names[code];
    endfunction

    // Outputs sampled mid-cycle, well away from the drive point
    always @(negedge clk_48) begin
        while (due_q.size() > 0 && due_q[0] == cyc) begin
            got = probe(code_q[0]);
            n_chk++;
            assert (got === exp_q[0]) else begin
                n_err++;
                $display("MISMATCH at time %0t: %s is %0h, expected %0h",
                         $time, sig_name(code_q[0]), got, exp_q[0]);
            end
            void'(due_q.pop_front());
            void'(code_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    always @(posedge clk_48) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("Timeout: run stopped after %0d cycles, %0d checks pending",
                     cyc, due_q.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Stimulus --------------------
    task automatic next_cycle();
        @(posedge clk_48);
        #5; // Drive point
    endtask

    task automatic expect_sig(input int code, input logic [255:0] value, input int delay);
        due_q.push_back(cyc + delay);
        code_q.push_back(code);
        exp_q.push_back(value);
    endtask

    task automatic end_test(input string name);
        while (due_q.size() > 0) next_cycle();
        $display("test %s: %0d checks, %0d errors", name, n_chk - chk_base, n_err - err_base);
        chk_base = n_chk;
        err_base = n_err;
    endtask

    task automatic load_byte(input int slot);
        logic [13:0] off;
        logic [7:0]  data;
        logic [9:0]  bank;
        int          bit_no;
        off        = 14'(rnd(14));
        data       = 8'(rnd(8));
        bank       = boot_bank(slot, ioctl_index);
        ioctl_addr = {11'(slot), off};
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        expect_sig(SIG_BOOT_WR, 256'(bank[9]), 1);
        if (bank[9]) begin
            expect_sig(SIG_BOOT_A, 256'({bank[8:0], off}), 1);
            expect_sig(SIG_BOOT_DOUT, 256'(data), 1);
            bit_no = rom_map_bit(bank[8:0]);
            if (bit_no >= 0) exp_map[bit_no] = 1'b1;
        end
        next_cycle();
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        logic [12:0] a;
        a = shadow_addr(port, data, tb_pen, tb_crtc); // Old latch values
        if (a != 13'h0000) begin
            ref_mem[a] = data;
            written_q.push_back(a);
        end
        if (port == 8'h7F && data[7:6] == 2'b00) tb_pen = data[4:0];
        if (port == 8'hBC) tb_crtc = data[3:0];
        cpu_addr = {port, 8'(rnd(8))};
        cpu_dout = data;
        iorq     = 1'b1;
        wr       = 1'b1;
        repeat (2) next_cycle(); // Held until the store is registered
        iorq = 1'b0;
        wr   = 1'b0;
        next_cycle();
    endtask

    task automatic mem_write(input logic [12:0] a, input logic [7:0] data);
        ref_mem[a] = data;
        written_q.push_back(a);
        cpu_addr = {3'b001, a}; // RAM window 2000..3FFF
        cpu_dout = data;
        mem_wr   = 1'b1;
        repeat (3) next_cycle();
        mem_wr = 1'b0;
        next_cycle();
    endtask

    initial begin
        logic [12:0] a;
        logic [7:0]  d;
        logic [7:0]  port;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ioctl_index    = '0;
        cpu_addr       = '0;
        cpu_dout       = '0;
        m1             = 1'b0;
        iorq           = 1'b0;
        wr             = 1'b0;
        mem_rd         = 1'b0;
        mem_wr         = 1'b0;
        key_nmi        = 1'b0;
        repeat (16) next_cycle();
        reset = 1'b0;

        expect_sig(SIG_CORE_RESET, 256'(1), 1);
        expect_sig(SIG_ROM_LOADED, 256'(0), 1);
        expect_sig(SIG_BOOT_WR, 256'(0), 1);
        expect_sig(SIG_MF2_EN, 256'(0), 1);
        expect_sig(SIG_ROM_MAP, 256'(0), 1);
        expect_sig(SIG_MF2_DOUT, 256'(8'hFF), 1);
        end_test("1 reset");

        // Firmware slots 0..5, then one byte of a non-ROM index
        ioctl_download = 1'b1;
        next_cycle();
        for (int s = 0; s < 6; s++) begin
            for (int k = 0; k < DL_BYTES; k++) load_byte(s);
        end
        ioctl_index = 8'd4;
        load_byte(0);
        ioctl_wr = 1'b0;
        repeat (2) next_cycle(); // ROM map lags boot_wr
        expect_sig(SIG_ROM_MAP, exp_map, 1);
        end_test("2 download");

        ioctl_download = 1'b0;
        expect_sig(SIG_ROM_LOADED, 256'(1), 1);
        expect_sig(SIG_CORE_RESET, 256'(0), 1);
        end_test("3 download end");

        key_nmi = 1'b1;
        next_cycle();
        m1       = 1'b1;
        cpu_addr = 16'h0066; // NMI fetch
        expect_sig(SIG_MF2_EN, 256'(1), 1);
        expect_sig(SIG_MF2_ROM_EN, 256'(1), 1);
        next_cycle();
        m1      = 1'b0;
        key_nmi = 1'b0;
        end_test("4 nmi entry");

        // Latches first, then random port and RAM traffic
        io_write(8'h7F, {3'b000, 5'(rnd(5))});
        io_write(8'h7F, {2'b01, 6'(rnd(6))});
        io_write(8'hBC, 8'(rnd(8)));
        for (int i = 0; i < N_IO; i++) begin
            case (3'(rnd(3)))
                3'd0, 3'd1, 3'd2: port = 8'h7F; // Gate array weighted up
                3'd3:             port = 8'hBC;
                3'd4, 3'd5:       port = 8'hBD;
                3'd6:             port = 8'hF7;
                default:          port = 8'hDF;
            endcase
            d = 8'(rnd(8));
            io_write(port, d);
        end
        for (int i = 0; i < N_MEM; i++) begin
            a = 13'(rnd(13));
            d = 8'(rnd(8));
            mem_write(a, d);
        end
        mem_rd = 1'b1;
        foreach (written_q[i]) begin
            cpu_addr = {3'b001, written_q[i]}; // One read per cycle, pipelined
            expect_sig(SIG_MF2_DOUT, 256'(ref_mem[written_q[i]]), 2);
            next_cycle();
        end
        end_test("5 shadow and ram");
        mem_rd = 1'b0;

        m1       = 1'b1;
        cpu_addr = 16'h0065; // Hide fetch
        expect_sig(SIG_MF2_EN, 256'(1), 1);
        next_cycle();
        m1 = 1'b0;
        next_cycle();
        cpu_addr = 16'hFEEA;
        iorq     = 1'b1;
        wr       = 1'b1;
        expect_sig(SIG_MF2_EN, 256'(0), 1);
        next_cycle();
        iorq = 1'b0;
        wr   = 1'b0;
        next_cycle();
        cpu_addr = 16'hFEE8; // No effect while hidden
        iorq     = 1'b1;
        wr       = 1'b1;
        expect_sig(SIG_MF2_EN, 256'(0), 1);
        expect_sig(SIG_MF2_EN, 256'(0), 2);
        next_cycle();
        iorq = 1'b0;
        wr   = 1'b0;
        end_test("6 hide and ports");

        $display("done: %0d checks, %0d errors", n_chk, n_err);
        if (n_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/cpc_pkg.sv
hdl/boot_loader.sv
hdl/mf2_control.sv
hdl/mf2_shadow.sv
hdl/mf2_ram.sv
hdl/cpc_sim_top.sv
sim/tb_top.sv
